// ==== lineCar.f ====
+incdir+bench
verilog/lineCarPkg.sv
verilog/inputSync.sv
verilog/phaseTimer.sv
verilog/routeFsm.sv
verilog/statusDisplay.sv
verilog/lineCar.sv
bench/lineCarTb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := lineCarTb
FILELIST  := lineCar.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/lineCarTasks.svh ====
`ifndef LINECARTASKS_SVH
`define LINECARTASKS_SVH

// Advance to the drive point just after the next rising edge
task automatic nextCycle();
    @(posedge clk);
    #2;
endtask

// Pattern bits are {left, mid, right}
task automatic setTrack(input logic [2:0] pattern);
    leftTrack  = pattern[2];
    midTrack   = pattern[1];
    rightTrack = pattern[0];
endtask

task automatic reportMismatch(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
    failRun($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic checkValue(input string what, input logic [15:0] got,
                          input logic [15:0] exp);
    assert (got === exp)
        else reportMismatch(what, got, exp);
endtask

task automatic waitLamps(input logic [4:0] expLamps, input int limit, output int cycles);
    cycles = 0;
    while (led.stateLamps !== expLamps && cycles < limit) begin
        nextCycle();
        cycles++;
    end
    assert (led.stateLamps === expLamps)
        else failRun($sformatf("State lamps did not reach %b within %0d cycles",
                               expLamps, limit));
endtask

task automatic waitDigits(input logic [15:0] expDigits, input int limit, output int cycles);
    cycles = 0;
    while (digits !== expDigits && cycles < limit) begin
        nextCycle();
        cycles++;
    end
    assert (digits === expDigits)
        else failRun($sformatf("Digit codes did not reach %h within %0d cycles",
                               expDigits, limit));
endtask

`endif

// ==== bench/lineCarTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineCarTb;
    import lineCarPkg::*;

    localparam int countCycles    = 8;
    localparam int stopCycles     = 6;
    localparam int backCycles     = 4;
    localparam int lampCycles     = 5;
    localparam int finishDistance = 2;
    // Whole sequence needs well under 100 cycles
    localparam int maxCycles      = 400;

    localparam logic [4:0] lampsIdle     = 5'b00000;
    localparam logic [4:0] lampsStart    = 5'b00001;
    localparam logic [4:0] lampsCount    = 5'b00010;
    localparam logic [4:0] lampsStraight = 5'b01000;
    localparam logic [4:0] lampsLeft     = 5'b10000;
    localparam logic [4:0] lampsStop     = 5'b11100;
    localparam logic [4:0] lampsBack     = 5'b01010;

    localparam logic [15:0] idleDigits   = 16'h1CDE;
    localparam logic [15:0] dashDigits   = 16'hBBBB;
    localparam logic [15:0] lineDigits   = 16'hA2B1;
    localparam logic [15:0] finishDigits = 16'hAAAA;

    logic                     clk;
    logic                     rst;
    logic                     leftTrack;
    logic                     midTrack;
    logic                     rightTrack;
    logic                     run;
    logic [distanceWidth-1:0] distance;
    ledFrame                  led;
    digitCodes                digits;

    int          cycleCount = 0;
    int          taken;
    int          k;
    int          quarter;
    int          expLast;
    logic        flashExp;
    integer      seed;
    integer      randomWord;

    lineCar #(
        .countCycles   (countCycles),
        .stopCycles    (stopCycles),
        .backCycles    (backCycles),
        .lampCycles    (lampCycles),
        .finishDistance(finishDistance)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .leftTrack (leftTrack),
        .midTrack  (midTrack),
        .rightTrack(rightTrack),
        .run       (run),
        .distance  (distance),
        .led       (led),
        .digits    (digits)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: the sequence did not complete within %0d cycles", maxCycles);
            $display("Checks failed");
            $fatal(1);
        end
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    `include "lineCarTasks.svh"

    initial begin
        seed       = 32'h34f;
        rst        = 1'b1;
        run        = 1'b0;
        distance   = 20'd100;
        setTrack(3'b000);
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        checkValue("idle lamps", 16'(led.stateLamps), 16'(lampsIdle));
        checkValue("idle digits", digits, idleDigits);

        // Two flops between the track and the road field
        setTrack(3'b101);
        nextCycle();
        checkValue("road after one cycle", 16'(led.road), 16'h0000);
        nextCycle();
        checkValue("road after two cycles", 16'(led.road), 16'h0005);

        run = 1'b1;
        waitLamps(lampsStart, 5, taken);
        checkValue("cycles to start", 16'(taken), 16'd3);
        checkValue("start digits", digits, dashDigits);

        setTrack(3'b010);
        waitLamps(lampsCount, 5, taken);
        checkValue("cycles to count", 16'(taken), 16'd3);
        for (k = 0; k <= countCycles; k++) begin
            quarter = (k * 4) / countCycles;
            if (quarter > 3)
                quarter = 3;
            expLast  = 3 - quarter;
            flashExp = ((k / (countCycles / 2)) % 2) == 1;
            checkValue("count lamps", 16'(led.stateLamps), 16'(lampsCount));
            checkValue("countdown digits", digits, {12'hBBB, expLast[3:0]});
            checkValue("count motion", 16'(led.motion), flashExp ? 16'h0000 : 16'h003F);
            nextCycle();
        end
        checkValue("lamps after countdown", 16'(led.stateLamps), 16'(lampsStraight));
        checkValue("straight motion", 16'(led.motion), 16'h000C);

        setTrack(3'b011);
        repeat (3) nextCycle();
        checkValue("little right lamps", 16'(led.stateLamps), 16'h0000);
        checkValue("little right motion", 16'(led.motion), 16'h0000);
        checkValue("little right digits", digits, lineDigits);

        setTrack(3'b110);
        repeat (3) nextCycle();
        checkValue("little left road", 16'(led.road), 16'h0006);
        checkValue("little left lamps", 16'(led.stateLamps), 16'h0000);
        checkValue("little left digits", digits, lineDigits);

        setTrack(3'b010);
        waitLamps(lampsStraight, 4, taken);
        checkValue("cycles back to straight", 16'(taken), 16'd3);

        // Dead end, pause, then reverse
        setTrack(3'b000);
        waitLamps(lampsStop, 4, taken);
        checkValue("cycles to stop", 16'(taken), 16'd3);
        checkValue("stop motion", 16'(led.motion), 16'h003F);
        assert (digits.num3 == 4'd1 || digits.num3 == 4'd11)
            else reportMismatch("stop resume digit", 16'(digits.num3), 16'h000B);
        waitLamps(lampsBack, stopCycles + 3, taken);
        checkValue("stop pause length", 16'(taken), 16'(stopCycles + 1));
        for (k = 0; k < 2 * backCycles; k++) begin
            flashExp = ((k / (backCycles / 2)) % 2) == 1;
            checkValue("back lamps", 16'(led.stateLamps), 16'(lampsBack));
            checkValue("back motion", 16'(led.motion), flashExp ? 16'h0000 : 16'h003F);
            nextCycle();
        end

        setTrack(3'b111);
        waitLamps(lampsStop, 4, taken);
        checkValue("cycles from back to stop", 16'(taken), 16'd3);
        waitLamps(lampsLeft, stopCycles + 3, taken);
        checkValue("second pause length", 16'(taken), 16'(stopCycles + 1));

        distance = 20'(finishDistance - 1);
        nextCycle();
        checkValue("obstacle leds", led, 16'hFFFF);
        checkValue("obstacle digits", digits, finishDigits);
        for (k = 0; k < 6; k++) begin
            randomWord = $random(seed);
            setTrack(randomWord[2:0]);
            nextCycle();
            checkValue("obstacle leds with noise", led, 16'hFFFF);
            checkValue("obstacle digits with noise", digits, finishDigits);
        end

        distance = 20'd100;
        run      = 1'b0;
        waitDigits(idleDigits, 3, taken);
        checkValue("lamps after run off", 16'(led.stateLamps), 16'(lampsIdle));

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/lineCar.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineCar #(
    parameter int countCycles    = 100000000,
    parameter int stopCycles     = 50000000,
    parameter int backCycles     = 25000000,
    parameter int lampCycles     = 30000000,
    parameter int finishDistance = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               leftTrack,
    input  logic                               midTrack,
    input  logic                               rightTrack,
    input  logic                               run,
    input  logic [lineCarPkg::distanceWidth-1:0] distance,
    output lineCarPkg::ledFrame                led,
    output lineCarPkg::digitCodes              digits
);
    import lineCarPkg::*;

    roadPattern road;
    routeStatus status;
    logic       runSync;
    logic       near;
    logic       countEn;
    logic       stopEn;
    logic       backEn;
    logic       countDone;
    logic       countFlash;
    logic [1:0] countPhase;
    logic       restart;
    logic       backFlash;

    // Obstacle closer than the threshold
    assign near = (distance < distanceWidth'(finishDistance));

    inputSync sync_i (
        .clk       (clk),
        .rst       (rst),
        .leftTrack (leftTrack),
        .midTrack  (midTrack),
        .rightTrack(rightTrack),
        .run       (run),
        .road      (road),
        .runSync   (runSync)
    );

    routeFsm fsm_i (
        .clk      (clk),
        .rst      (rst),
        .road     (road),
        .runSync  (runSync),
        .near     (near),
        .countDone(countDone),
        .restart  (restart),
        .status   (status),
        .countEn  (countEn),
        .stopEn   (stopEn),
        .backEn   (backEn)
    );

    phaseTimer #(.length(countCycles)) countTimer_i (
        .clk   (clk),
        .rst   (rst),
        .enable(countEn),
        .done  (countDone),
        .flash (countFlash),
        .phase (countPhase)
    );

    phaseTimer #(.length(stopCycles)) stopTimer_i (
        .clk   (clk),
        .rst   (rst),
        .enable(stopEn),
        .done  (restart),
        .flash (),
        .phase ()
    );

    phaseTimer #(.length(backCycles)) backTimer_i (
        .clk   (clk),
        .rst   (rst),
        .enable(backEn),
        .done  (),
        .flash (backFlash),
        .phase ()
    );

    statusDisplay #(.lampCycles(lampCycles)) display_i (
        .clk       (clk),
        .rst       (rst),
        .status    (status),
        .road      (road),
        .near      (near),
        .countPhase(countPhase),
        .countFlash(countFlash),
        .backFlash (backFlash),
        .restart   (restart),
        .led       (led),
        .digits    (digits)
    );

endmodule

`default_nettype wire

// ==== verilog/statusDisplay.sv ====
`timescale 1ns/100ps
`default_nettype none

module statusDisplay #(
    parameter int lampCycles = 30000000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  lineCarPkg::routeStatus status,
    input  lineCarPkg::roadPattern road,
    input  logic                   near,
    input  logic [1:0]             countPhase,
    input  logic                   countFlash,
    input  logic                   backFlash,
    input  logic                   restart,
    output lineCarPkg::ledFrame    led,
    output lineCarPkg::digitCodes  digits
);
    import lineCarPkg::*;

    localparam int lampWidth = $clog2(lampCycles + 1);

    logic [lampWidth-1:0] lampCnt;
    logic [2:0]           chooseLamp;
    ledFrame              frame;

    // Symbol for the resume target
    function automatic logic [3:0] resumeCode(driveState s);
        case (s)
            idle:     return codeIdleA;
            straight: return 4'd1;
            left:     return codeIdleB;
            right:    return codeRight;
            back:     return codeDash;
            default:  return 4'd0;
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCnt    <= '0;
            chooseLamp <= 3'b001;
        end else if (status.state == choose) begin
            if (lampCnt == lampWidth'(lampCycles - 1)) begin
                lampCnt    <= '0;
                chooseLamp <= {chooseLamp[1:0], chooseLamp[2]};
            end else begin
                lampCnt <= lampCnt + 1'b1;
            end
        end else begin
            lampCnt    <= '0;
            chooseLamp <= 3'b001;
        end
    end

    always_comb begin
        frame.gapHigh = 1'b0;
        frame.gapLow  = 1'b0;
        frame.road    = road;
        case (status.state)
            idle:     frame.stateLamps = 5'b00000;
            start:    frame.stateLamps = 5'b00001;
            count:    frame.stateLamps = 5'b00010;
            straight: frame.stateLamps = 5'b01000;
            choose:   frame.stateLamps = {chooseLamp, 2'b00};
            left:     frame.stateLamps = 5'b10000;
            right:    frame.stateLamps = 5'b00100;
            stop:     frame.stateLamps = 5'b11100;
            back:     frame.stateLamps = 5'b01010;
            error:    frame.stateLamps = 5'b11111;
            default:  frame.stateLamps = 5'b00000;
        endcase
        case (status.state)
            count:    frame.motion = countFlash ? 6'b000000 : 6'b111111;
            straight: frame.motion = 6'b001100;
            right:    frame.motion = 6'b000011;
            left:     frame.motion = 6'b110000;
            stop:     frame.motion = 6'b111111;
            back:     frame.motion = {6{~backFlash}};
            default:  frame.motion = 6'b000000;
        endcase
    end

    // Obstacle lights everything
    assign led = near ? ledFrame'('1) : frame;

    always_comb begin
        case (status.state)
            idle:   digits = '{4'd1, codeIdleA, codeIdleB, codeIdleC};
            start:  digits = '{codeDash, codeDash, codeDash, codeDash};
            count:  digits = '{codeDash, codeDash, codeDash, 4'd3 - {2'b00, countPhase}};
            straight, littleLeft, littleRight:
                digits = '{codeBar, 4'd2, codeDash, {3'b000, status.cp.cp2}};
            choose: digits = '{codeBar, 4'd1, codeDash, {3'b000, status.cp.cp1}};
            left:   digits = '{codeBar, 4'd3, codeDash, {3'b000, status.cp.cp3}};
            right: begin
                digits.num0 = 4'd4;
                digits.num1 = {3'b000, status.cp.cp4};
                digits.num2 = codeDash;
                digits.num3 = (status.rightCount >= 2'd2) ? 4'd2 :
                              {2'b00, status.rightCount};
            end
            back:   digits = '{codeDash, 4'd0, 4'd0, resumeCode(status.storeState)};
            stop: begin
                digits.num0 = {3'b000, restart};
                digits.num1 = 4'd0;
                digits.num2 = 4'd0;
                digits.num3 = resumeCode(status.storeState);
            end
            finish: digits = '{codeBar, codeBar, codeBar, codeBar};
            default: digits = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/routeFsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module routeFsm (
    input  logic                   clk,
    input  logic                   rst,
    input  lineCarPkg::roadPattern road,
    input  logic                   runSync,
    input  logic                   near,
    input  logic                   countDone,
    input  logic                   restart,
    output lineCarPkg::routeStatus status,
    output logic                   countEn,
    output logic                   stopEn,
    output logic                   backEn
);
    import lineCarPkg::*;

    driveState  state;
    driveState  nextState;
    driveState  lastState;
    driveState  storeState;
    driveState  transitionState;
    checkPoints cp;
    logic       pop;
    logic       popNext;
    logic [1:0] rightCount;
    logic       rightDone;
    logic       right111;
    logic       right111Prev;
    logic       straightGroup;

    assign straightGroup = (state == straight) || (state == littleLeft) ||
                           (state == littleRight);
    assign right111 = (state == right) && (road == turn111);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= idle;
            lastState <= idle;
        end else if (!runSync) begin
            state <= idle;
        end else if (near) begin
            state <= finish;
        end else begin
            state     <= nextState;
            lastState <= state;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle:  if (runSync) nextState = start;
            start: if (road == straightRoad) nextState = count;
            count: if (countDone) nextState = straight;
            straight, littleLeft, littleRight: begin
                case (road)
                    rightRoad, rightLittle: nextState = littleRight;
                    leftRoad, leftLittle:   nextState = littleLeft;
                    errorRoad:              nextState = stop;
                    turn111:                nextState = cp.cp2 ? choose : straight;
                    default:                nextState = straight;
                endcase
            end
            choose: begin
                if (road == turn101)
                    nextState = stop;
                else if (road == turn111 && cp.cp1)
                    nextState = straight;
            end
            left: begin
                if ((road == turn101 && cp.cp5) || (road == turn111 && cp.cp3))
                    nextState = stop;
            end
            right: begin
                if (road == turn101 && rightDone)
                    nextState = error;
                else if (road == turn111 && cp.cp4 && rightDone)
                    nextState = stop;
            end
            back:  if (road == turn111) nextState = stop;
            stop:  if (restart) nextState = storeState;
            error: if (!runSync) nextState = idle;
            default: nextState = state;
        endcase
    end

    // Where to go once the stop pause ends
    always_comb begin
        transitionState = storeState;
        popNext         = pop;
        case (state)
            straight, littleLeft, littleRight:
                transitionState = (road == errorRoad) ? back : straight;
            choose:
                transitionState = (road == turn101) ? left : choose;
            left: begin
                if (road == turn101)
                    transitionState = right;
                else if (road == turn111)
                    transitionState = straight;
                else
                    transitionState = left;
            end
            right:
                transitionState = (road == turn111) ? straight : right;
            back: begin
                if (road == turn111 && !pop) begin
                    transitionState = left;
                    popNext         = 1'b1;
                end else if (road == turn111) begin
                    transitionState = right;
                end
            end
            default: transitionState = storeState;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cp         <= '0;
            pop        <= 1'b0;
            storeState <= left;
        end else begin
            storeState <= transitionState;
            pop        <= popNext;

            if (state == choose && road != turn111)
                cp.cp1 <= 1'b1;
            else if (state != choose)
                cp.cp1 <= 1'b0;

            if (lastState == count || (straightGroup && road != turn111))
                cp.cp2 <= 1'b1;
            else if (!straightGroup)
                cp.cp2 <= 1'b0;

            if (state == left && road != turn111)
                cp.cp3 <= 1'b1;
            else if (state != left)
                cp.cp3 <= 1'b0;

            if (state == right && road != turn111)
                cp.cp4 <= 1'b1;
            else if (state != right)
                cp.cp4 <= 1'b0;

            if (state == left && road != turn101)
                cp.cp5 <= 1'b1;
            else if (state != left)
                cp.cp5 <= 1'b0;
        end
    end

    // Counts 111 crossings in the right branch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rightCount   <= 2'd0;
            rightDone    <= 1'b0;
            right111Prev <= 1'b0;
        end else begin
            right111Prev <= right111;
            if (state != right) begin
                rightCount <= 2'd0;
                rightDone  <= 1'b0;
            end else begin
                if (cp.cp4 && right111 && !right111Prev && rightCount != 2'd3)
                    rightCount <= rightCount + 2'd1;
                if (rightCount >= 2'd2)
                    rightDone <= 1'b1;
            end
        end
    end

    assign countEn = (state == count);
    assign stopEn  = (state == stop);
    assign backEn  = (state == back);

    always_comb begin
        status.state      = state;
        status.storeState = storeState;
        status.cp         = cp;
        status.rightCount = rightCount;
    end

endmodule

`default_nettype wire

// ==== verilog/phaseTimer.sv ====
`timescale 1ns/100ps
`default_nettype none

module phaseTimer #(
    parameter int length = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    output logic       done,
    output logic       flash,
    output logic [1:0] phase
);
    localparam int cntWidth   = $clog2(length + 1);
    localparam int halfLength = (length / 2 > 0) ? length / 2 : 1;
    localparam int halfWidth  = $clog2(halfLength + 1);

    logic [cntWidth-1:0]  cnt;
    logic [halfWidth-1:0] halfCnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            halfCnt <= '0;
            flash   <= 1'b0;
        end else if (!enable) begin
            cnt     <= '0;
            halfCnt <= '0;
            flash   <= 1'b0;
        end else begin
            // Saturates at length
            if (cnt != cntWidth'(length))
                cnt <= cnt + 1'b1;
            if (halfCnt == halfWidth'(halfLength - 1)) begin
                halfCnt <= '0;
                flash   <= ~flash;
            end else begin
                halfCnt <= halfCnt + 1'b1;
            end
        end
    end

    assign done = (cnt == cntWidth'(length));

    always_comb begin
        if (cnt >= cntWidth'(3 * length / 4))
            phase = 2'd3;
        else if (cnt >= cntWidth'(length / 2))
            phase = 2'd2;
        else if (cnt >= cntWidth'(length / 4))
            phase = 2'd1;
        else
            phase = 2'd0;
    end

endmodule

`default_nettype wire

// ==== verilog/inputSync.sv ====
`timescale 1ns/100ps
`default_nettype none

module inputSync (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   leftTrack,
    input  logic                   midTrack,
    input  logic                   rightTrack,
    input  logic                   run,
    output lineCarPkg::roadPattern road,
    output logic                   runSync
);
    import lineCarPkg::*;

    logic [3:0] stage1;
    logic [3:0] stage2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage1 <= '0;
            stage2 <= '0;
        end else begin
            stage1 <= {leftTrack, midTrack, rightTrack, run};
            stage2 <= stage1;
        end
    end

    assign road    = roadPattern'(stage2[3:1]);
    assign runSync = stage2[0];

endmodule

`default_nettype wire

// ==== verilog/lineCarPkg.sv ====
`default_nettype none

package lineCarPkg;

    // Sensor bits as {left, mid, right}
    typedef enum logic [2:0] {
        errorRoad    = 3'b000,
        rightLittle  = 3'b001,
        straightRoad = 3'b010,
        rightRoad    = 3'b011,
        leftLittle   = 3'b100,
        turn101      = 3'b101,
        leftRoad     = 3'b110,
        turn111      = 3'b111
    } roadPattern;

    typedef enum logic [4:0] {
        idle        = 5'd0,
        start       = 5'd1,
        count       = 5'd2,
        straight    = 5'd3,
        choose      = 5'd4,
        left        = 5'd5,
        right       = 5'd6,
        back        = 5'd7,
        littleLeft  = 5'd8,
        littleRight = 5'd9,
        finish      = 5'd29,
        stop        = 5'd30,
        error       = 5'd31
    } driveState;

    typedef struct packed {
        logic cp1;
        logic cp2;
        logic cp3;
        logic cp4;
        logic cp5;
    } checkPoints;

    typedef struct packed {
        driveState  state;
        driveState  storeState;
        checkPoints cp;
        logic [1:0] rightCount;
    } routeStatus;

    typedef struct packed {
        logic [3:0] num0;
        logic [3:0] num1;
        logic [3:0] num2;
        logic [3:0] num3;
    } digitCodes;

    typedef struct packed {
        logic [4:0] stateLamps;
        logic       gapHigh;
        logic [5:0] motion;
        logic       gapLow;
        logic [2:0] road;
    } ledFrame;

    // Symbol codes beyond the decimal digits
    localparam logic [3:0] codeBar   = 4'd10;
    localparam logic [3:0] codeDash  = 4'd11;
    localparam logic [3:0] codeIdleA = 4'd12;
    localparam logic [3:0] codeIdleB = 4'd13;
    localparam logic [3:0] codeIdleC = 4'd14;
    localparam logic [3:0] codeRight = 4'd15;

    localparam int distanceWidth = 20;

endpackage

`default_nettype wire
